// ==== vlog.f ====
+incdir+src
src/mem_pkg.sv
src/lsu_align.sv
src/dtim.sv
src/memory_stage.sv
src/writeback_stage.sv
src/memory_subsystem.sv
tb/tb_clock.sv
tb/tb_memory_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_memory_subsystem -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_memory_subsystem > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
  echo "no pass line found in $log"
  exit 1
fi
exit 0

// ==== tb/tb_memory_subsystem.sv ====
`include "mem_defs.svh"

module tb_memory_subsystem import mem_pkg::*; ();

  localparam int wait_cycles = `DTIM_WAIT;
  localparam int byte_aw = $clog2(`DTIM_WORDS * 4);
  localparam int num_ops = 40;
  localparam int cycle_limit = num_ops * (wait_cycles + 4) + 100;

  logic clock;
  logic reset;
  logic ex_valid;
  mem_op_t ex_op;
  mem_size_t ex_size;
  logic ex_unsigned;
  addr_t ex_addr;
  word_t ex_sdata;
  word_t ex_wdata;
  reg_addr_t ex_waddr;
  logic flush;
  reg_addr_t rs_addr = '0;
  logic stall;
  logic fwd_wren;
  reg_addr_t fwd_waddr;
  word_t fwd_wdata;
  word_t rs_data;
  word_t instret;

  // reference models
  logic [7:0] ref_mem [2 ** byte_aw];
  word_t reg_model [2 ** `REG_ADDR_W];
  word_t exp_rs_data;
  word_t exp_instret;
  logic exp_stall;
  logic exp_fwd_wren;
  reg_addr_t exp_fwd_waddr;
  word_t exp_fwd_wdata;

  addr_t word_addrs [6];
  reg_addr_t rd;
  int value_errors = 0;
  int other_errors = 0;
  int cycles = 0;

  tb_clock #(.period(100)) u_tb_clock (.clock(clock));

  memory_subsystem u_memory_subsystem (.*);

  assign exp_rs_data = reg_model[rs_addr];

  always @(posedge clock) begin
    rs_addr <= rs_addr + 1'b1;  // read port walks the whole file
  end

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    value_errors++;
    $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
  endtask

  task automatic print_error_counts();
    $display("error count: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
  endtask

  a_stall: assert property (@(negedge clock) disable iff (!reset) stall == exp_stall)
    else report_mismatch("stall", word_t'(exp_stall), word_t'(stall));
  a_fwd_wren: assert property (@(negedge clock) disable iff (!reset) fwd_wren == exp_fwd_wren)
    else report_mismatch("fwd_wren", word_t'(exp_fwd_wren), word_t'(fwd_wren));
  a_fwd_waddr: assert property (@(negedge clock) disable iff (!reset)
    exp_fwd_wren |-> fwd_waddr == exp_fwd_waddr)
    else report_mismatch("fwd_waddr", word_t'(exp_fwd_waddr), word_t'(fwd_waddr));
  a_fwd_wdata: assert property (@(negedge clock) disable iff (!reset)
    exp_fwd_wren |-> fwd_wdata == exp_fwd_wdata)
    else report_mismatch("fwd_wdata", exp_fwd_wdata, fwd_wdata);
  a_instret: assert property (@(negedge clock) disable iff (!reset) instret == exp_instret)
    else report_mismatch("instret", exp_instret, instret);
  a_rs_data: assert property (@(negedge clock) disable iff (!reset) rs_data == exp_rs_data)
    else report_mismatch("rs_data", exp_rs_data, rs_data);

  // little endian bytes, sign or zero extended to a word
  function automatic word_t expected_load(input addr_t addr, input mem_size_t size,
                                          input logic is_unsigned);
    logic [byte_aw-1:0] base;
    logic [7:0] b0;
    logic [15:0] h0;
    word_t val;
    base = addr[byte_aw-1:0];
    b0 = ref_mem[base];
    h0 = {ref_mem[base + byte_aw'(1)], ref_mem[base]};
    case (size)
      size_byte: val = is_unsigned ? {24'h0, b0} : {{24{b0[7]}}, b0};
      size_half: val = is_unsigned ? {16'h0, h0} : {{16{h0[15]}}, h0};
      default: val = {ref_mem[base + byte_aw'(3)], ref_mem[base + byte_aw'(2)], h0};
    endcase
    return val;
  endfunction

  task automatic store_to_model(input addr_t addr, input mem_size_t size, input word_t data);
    logic [byte_aw-1:0] base;
    base = addr[byte_aw-1:0];
    ref_mem[base] = data[7:0];
    if (size != size_byte) ref_mem[base + byte_aw'(1)] = data[15:8];
    if (size == size_word) begin
      ref_mem[base + byte_aw'(2)] = data[23:16];
      ref_mem[base + byte_aw'(3)] = data[31:24];
    end
  endtask

  function automatic reg_addr_t random_reg();
    return reg_addr_t'(1 + $urandom % 31);
  endfunction

  task automatic wait_stall_low();
    int n;
    n = 0;
    @(negedge clock);
    while (stall && n < 4 * wait_cycles) begin
      @(negedge clock);
      n++;
    end
    if (stall) begin
      other_errors++;
      $display("stall stuck high at %0t, a memory op never completed", $time);
    end
  endtask

  // one op through the stage, expected values follow the stage timing
  task automatic run_op(input mem_op_t op, input mem_size_t size, input logic is_unsigned,
                        input addr_t addr, input word_t data, input reg_addr_t waddr,
                        input logic kill);
    logic writes;
    word_t value;
    writes = (op == op_load || op == op_alu);
    value = (op == op_load) ? expected_load(addr, size, is_unsigned) : data;
    @(posedge clock);
    ex_valid <= 1'b1;
    ex_op <= op;
    ex_size <= size;
    ex_unsigned <= is_unsigned;
    ex_addr <= addr;
    ex_sdata <= data;
    ex_wdata <= data;
    ex_waddr <= waddr;
    @(posedge clock);
    ex_valid <= 1'b0;
    if (kill) begin
      flush <= 1'b1;  // op sits in the stage this cycle
      @(posedge clock);
      flush <= 1'b0;
    end else begin
      if (op == op_load || op == op_store) begin
        exp_stall <= 1'b1;
        repeat (wait_cycles) @(posedge clock);
        exp_stall <= 1'b0;
      end
      exp_fwd_wren <= writes;  // op leaves the stage
      exp_fwd_waddr <= waddr;
      exp_fwd_wdata <= value;
      if (op == op_store) store_to_model(addr, size, data);
      wait_stall_low();
      @(posedge clock);
      exp_fwd_wren <= 1'b0;
      @(posedge clock);
      exp_instret <= exp_instret + 1;
      if (writes && waddr != '0) reg_model[waddr] <= value;
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
      print_error_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(7));
    reset = 1'b0;
    ex_valid = 1'b0;
    ex_op = op_none;
    ex_size = size_word;
    ex_unsigned = 1'b0;
    ex_addr = '0;
    ex_sdata = '0;
    ex_wdata = '0;
    ex_waddr = '0;
    flush = 1'b0;
    exp_instret = '0;
    exp_stall = 1'b0;
    exp_fwd_wren = 1'b0;
    exp_fwd_waddr = '0;
    exp_fwd_wdata = '0;
    for (int i = 0; i < 2 ** `REG_ADDR_W; i++) begin
      reg_model[i] = '0;
    end
    repeat (4) @(posedge clock);
    reset <= 1'b1;
    repeat (34) @(posedge clock);  // all registers must read zero after reset

    // word round trip
    for (int i = 0; i < 6; i++) begin
      word_addrs[i] = addr_t'(($urandom % `DTIM_WORDS) * 4);
      run_op(op_store, size_word, 1'b0, word_addrs[i], $urandom, '0, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      run_op(op_load, size_word, 1'b0, word_addrs[i], '0, random_reg(), 1'b0);
    end

    // partial stores, each word keeps at least one old lane
    run_op(op_store, size_byte, 1'b0, word_addrs[0] + 32'd1, $urandom, '0, 1'b0);
    run_op(op_store, size_half, 1'b0, word_addrs[0] + 32'd2, $urandom, '0, 1'b0);
    run_op(op_load, size_word, 1'b0, word_addrs[0], '0, random_reg(), 1'b0);
    run_op(op_store, size_byte, 1'b0, word_addrs[1], $urandom, '0, 1'b0);
    run_op(op_store, size_byte, 1'b0, word_addrs[1] + 32'd3, $urandom, '0, 1'b0);
    run_op(op_load, size_word, 1'b0, word_addrs[1], '0, random_reg(), 1'b0);
    run_op(op_store, size_byte, 1'b0, word_addrs[2] + 32'd2, $urandom, '0, 1'b0);
    run_op(op_store, size_half, 1'b0, word_addrs[2], $urandom, '0, 1'b0);
    run_op(op_load, size_word, 1'b0, word_addrs[2], '0, random_reg(), 1'b0);

    // load extension, lanes hold both signs
    run_op(op_store, size_word, 1'b0, word_addrs[3], 32'h80ff_7f01, '0, 1'b0);
    run_op(op_load, size_byte, 1'b1, word_addrs[3], '0, random_reg(), 1'b0);
    run_op(op_load, size_byte, 1'b0, word_addrs[3] + 32'd1, '0, random_reg(), 1'b0);
    run_op(op_load, size_byte, 1'b0, word_addrs[3] + 32'd2, '0, random_reg(), 1'b0);
    run_op(op_load, size_byte, 1'b1, word_addrs[3] + 32'd3, '0, random_reg(), 1'b0);
    run_op(op_load, size_half, 1'b0, word_addrs[3], '0, random_reg(), 1'b0);
    run_op(op_load, size_half, 1'b0, word_addrs[3] + 32'd2, '0, random_reg(), 1'b0);
    run_op(op_load, size_half, 1'b1, word_addrs[3] + 32'd2, '0, random_reg(), 1'b0);

    // alu pass-through and forwarding
    rd = random_reg();
    run_op(op_alu, size_word, 1'b0, '0, $urandom, rd, 1'b0);
    run_op(op_alu, size_word, 1'b0, '0, $urandom, random_reg(), 1'b0);
    run_op(op_alu, size_word, 1'b0, '0, $urandom, random_reg(), 1'b0);
    run_op(op_alu, size_word, 1'b0, '0, $urandom, '0, 1'b0);  // x0 stays zero
    run_op(op_alu, size_word, 1'b0, '0, $urandom, rd, 1'b0);
    run_op(op_none, size_word, 1'b0, '0, $urandom, random_reg(), 1'b0);
    run_op(op_alu, size_word, 1'b0, '0, '1, random_reg(), 1'b0);

    // flushed ops leave memory, registers and instret alone
    run_op(op_store, size_word, 1'b0, word_addrs[3], $urandom, '0, 1'b1);
    run_op(op_load, size_word, 1'b0, word_addrs[3], '0, random_reg(), 1'b1);
    run_op(op_alu, size_word, 1'b0, '0, $urandom, random_reg(), 1'b1);
    run_op(op_load, size_word, 1'b0, word_addrs[3], '0, random_reg(), 1'b0);

    repeat (34) @(posedge clock);
    print_error_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
  parameter int period = 100
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

endmodule

// ==== src/memory_subsystem.sv ====
module memory_subsystem import mem_pkg::*; (
  input logic clock,
  input logic reset,
  input logic ex_valid,
  input mem_op_t ex_op,
  input mem_size_t ex_size,
  input logic ex_unsigned,
  input addr_t ex_addr,
  input word_t ex_sdata,
  input word_t ex_wdata,
  input reg_addr_t ex_waddr,
  input logic flush,
  input reg_addr_t rs_addr,
  output logic stall,
  output logic fwd_wren,
  output reg_addr_t fwd_waddr,
  output word_t fwd_wdata,
  output word_t rs_data,
  output word_t instret
);

  dtim_if u_dtim_if ();
  wb_if u_wb_if ();

  memory_stage u_memory_stage (
    .clock(clock),
    .reset(reset),
    .ex_valid(ex_valid),
    .ex_op(ex_op),
    .ex_size(ex_size),
    .ex_unsigned(ex_unsigned),
    .ex_addr(ex_addr),
    .ex_sdata(ex_sdata),
    .ex_wdata(ex_wdata),
    .ex_waddr(ex_waddr),
    .flush(flush),
    .mem(u_dtim_if.requester),
    .wb(u_wb_if.source),
    .stall(stall),
    .fwd_wren(fwd_wren),
    .fwd_waddr(fwd_waddr),
    .fwd_wdata(fwd_wdata)
  );

  dtim u_dtim (
    .clock(clock),
    .reset(reset),
    .mem(u_dtim_if.memory)
  );

  writeback_stage u_writeback_stage (
    .clock(clock),
    .reset(reset),
    .wb(u_wb_if.sink),
    .rs_addr(rs_addr),
    .rs_data(rs_data),
    .instret(instret)
  );

endmodule

// ==== src/writeback_stage.sv ====
module writeback_stage import mem_pkg::*; (
  input logic clock,
  input logic reset,
  wb_if.sink wb,
  input reg_addr_t rs_addr,
  output word_t rs_data,
  output word_t instret
);

  localparam int num_regs = 2 ** $bits(reg_addr_t);

  word_t regs [num_regs];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.wren && wb.waddr != '0) begin  // x0 stays zero
      regs[wb.waddr] <= wb.wdata;
    end
  end

  assign rs_data = regs[rs_addr];

  // one count per retired op, writing or not
  always_ff @(posedge clock) begin
    if (!reset) begin
      instret <= '0;
    end else if (wb.valid) begin
      instret <= instret + 1'b1;
    end
  end

endmodule

// ==== src/memory_stage.sv ====
module memory_stage import mem_pkg::*; (
  input logic clock,
  input logic reset,
  input logic ex_valid,
  input mem_op_t ex_op,
  input mem_size_t ex_size,
  input logic ex_unsigned,
  input addr_t ex_addr,
  input word_t ex_sdata,
  input word_t ex_wdata,
  input reg_addr_t ex_waddr,
  input logic flush,
  dtim_if.requester mem,
  wb_if.source wb,
  output logic stall,
  output logic fwd_wren,
  output reg_addr_t fwd_waddr,
  output word_t fwd_wdata
);

  // stage register
  logic r_valid;
  mem_op_t r_op;
  mem_size_t r_size;
  logic r_unsigned;
  addr_t r_addr;
  word_t r_sdata;
  word_t r_wdata;
  reg_addr_t r_waddr;

  logic is_mem;
  logic done;
  logic wren;
  mem_size_t lsu_size;
  word_t st_wdata;
  strobe_t st_wstrb;
  word_t ld_data;
  word_t result;

  assign is_mem = r_valid && (r_op == op_load || r_op == op_store);
  assign lsu_size = is_mem ? r_size : size_byte;  // alu ops carry no real address

  lsu_align u_lsu_align (
    .addr(r_addr),
    .size(lsu_size),
    .is_unsigned(r_unsigned),
    .sdata(r_sdata),
    .rdata(mem.rdata),
    .wdata(st_wdata),
    .wstrb(st_wstrb),
    .ldata(ld_data)
  );

  assign mem.valid = is_mem && !flush;  // flush withdraws a pending request
  assign mem.addr = r_addr;
  assign mem.wdata = st_wdata;
  assign mem.wstrb = (r_op == op_store) ? st_wstrb : '0;

  assign stall = mem.valid && !mem.ready;
  assign done = r_valid && !flush && !stall;
  assign wren = (r_op == op_alu) || (r_op == op_load);
  assign result = (r_op == op_load) ? ld_data : r_wdata;

  assign fwd_wren = done && wren;
  assign fwd_waddr = r_waddr;
  assign fwd_wdata = result;

  always_ff @(posedge clock) begin
    if (!reset) begin
      r_valid <= 1'b0;
    end else if (flush) begin
      r_valid <= 1'b0;
    end else if (!stall) begin
      r_valid <= ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      r_op <= ex_op;
      r_size <= ex_size;
      r_unsigned <= ex_unsigned;
      r_addr <= ex_addr;
      r_sdata <= ex_sdata;
      r_wdata <= ex_wdata;
      r_waddr <= ex_waddr;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wb.valid <= 1'b0;
      wb.wren <= 1'b0;
    end else begin
      wb.valid <= done;
      wb.wren <= done && wren;
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      wb.waddr <= r_waddr;
      wb.wdata <= result;
    end
  end

  a_no_issue_in_stall: assert property (
    @(posedge clock) disable iff (!reset)
    stall |-> !ex_valid
  ) else $error("op issued while stage stalled");

endmodule

// ==== src/dtim.sv ====
`include "mem_defs.svh"

module dtim import mem_pkg::*; #(
  parameter int depth = `DTIM_WORDS,
  parameter int wait_states = `DTIM_WAIT
) (
  input logic clock,
  input logic reset,
  dtim_if.memory mem
);

  localparam int idx_w = $clog2(depth);
  localparam int cnt_w = $clog2(wait_states + 2);

  word_t ram [depth];
  logic [cnt_w-1:0] wait_cnt;
  logic [idx_w-1:0] idx;

  assign idx = mem.addr[idx_w+1:2];  // word address

  // counts cycles of a held request, restarts when valid drops
  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_cnt <= '0;
    end else if (!mem.valid || mem.ready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign mem.ready = mem.valid && (wait_cnt == cnt_w'(wait_states));
  assign mem.rdata = mem.ready ? ram[idx] : '0;

  always_ff @(posedge clock) begin
    if (mem.ready) begin
      for (int i = 0; i < 4; i++) begin
        if (mem.wstrb[i]) ram[idx][i*8 +: 8] <= mem.wdata[i*8 +: 8];
      end
    end
  end

  // a waiting request may be withdrawn but not changed
  a_request_held: assert property (
    @(posedge clock) disable iff (!reset)
    mem.valid && !mem.ready |=> !mem.valid ||
      ($stable(mem.addr) && $stable(mem.wdata) && $stable(mem.wstrb))
  ) else $error("dtim request changed before ready");

  a_addr_in_range: assert property (
    @(posedge clock) disable iff (!reset)
    mem.valid |-> mem.addr < addr_t'(depth * 4)  // upper bits would alias
  ) else $error("dtim address %h beyond the memory", mem.addr);

endmodule

// ==== src/lsu_align.sv ====
module lsu_align import mem_pkg::*; (
  input addr_t addr,
  input mem_size_t size,
  input logic is_unsigned,
  input word_t sdata,
  input word_t rdata,
  output word_t wdata,
  output strobe_t wstrb,
  output word_t ldata
);

  word_t shifted;

  // store side, data goes out on every lane and the strobe picks the lanes
  always_comb begin
    case (size)
      size_byte: begin
        wdata = {4{sdata[7:0]}};
        wstrb = strobe_t'(4'b0001) << addr[1:0];
      end
      size_half: begin
        wdata = {2{sdata[15:0]}};
        wstrb = strobe_t'(4'b0011) << {addr[1], 1'b0};
      end
      default: begin
        wdata = sdata;
        wstrb = 4'b1111;
      end
    endcase
  end

  // load side
  always_comb begin
    shifted = rdata >> {addr[1:0], 3'b000};  // addressed byte to lane 0
    case (size)
      size_byte: begin
        if (is_unsigned) ldata = word_t'(shifted[7:0]);
        else ldata = word_t'(signed'(shifted[7:0]));
      end
      size_half: begin
        if (is_unsigned) ldata = word_t'(shifted[15:0]);
        else ldata = word_t'(signed'(shifted[15:0]));
      end
      default: ldata = rdata;
    endcase
  end

  // no misaligned access support, the core must never issue one
  always_comb begin
    if (size == size_half) begin
      assert final (addr[0] == 1'b0)
        else $error("misaligned half access at %h", addr);
    end else if (size == size_word) begin
      assert final (addr[1:0] == 2'b00)
        else $error("misaligned word access at %h", addr);
    end
  end

endmodule

// ==== src/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`XLEN/8-1:0] strobe_t;

  typedef enum logic [1:0] {op_none, op_alu, op_load, op_store} mem_op_t;
  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

endpackage

// stage to data memory, zero wstrb is a read
interface dtim_if import mem_pkg::*; ();
  logic valid;
  addr_t addr;
  word_t wdata;
  strobe_t wstrb;
  logic ready;    // one cycle pulse
  word_t rdata;   // only meaningful with ready

  modport requester (output valid, addr, wdata, wstrb, input ready, rdata);
  modport memory (input valid, addr, wdata, wstrb, output ready, rdata);
endinterface

// retire strobe into the register file
interface wb_if import mem_pkg::*; ();
  logic valid;
  logic wren;
  reg_addr_t waddr;
  word_t wdata;

  modport source (output valid, wren, waddr, wdata);
  modport sink (input valid, wren, waddr, wdata);
endinterface

// ==== src/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data path width
`define XLEN 32
`define REG_ADDR_W 5

// data memory geometry
`define DTIM_WORDS 1024
`define DTIM_WAIT 2

`endif
